// File: compile.f
hdl/snakeGeometryPkg.sv
hdl/snakeControlPkg.sv
hdl/snakeRegisters.sv
hdl/snakeBody.sv
hdl/squarePainter.sv
hdl/snakeGame.sv
bench/benchClock.sv
bench/snakeGameTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the snake game testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module snakeGameTb \
    -f compile.f -o snakeSim > build.log 2>&1 \
    && ./obj_dir/snakeSim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

// File: bench/snakeGameTb.sv
/* directed tests for the snake game: APB access, apple and body draw,
   erase and move with wrap-around, self-collision */
`timescale 1ns/100ps

module snakeGameTb;
    import snakeGeometryPkg::*;
    import snakeControlPkg::*;

    localparam int ClockPeriod = 100;
    localparam int SquareSize = 4;
    localparam int BodyLength = 6;
    localparam int ApplePixels = SquareSize * SquareSize;
    localparam int BodyPixels = BodyLength * ApplePixels;
    localparam int FramePixels = ApplePixels + 2 * BodyPixels;
    // reset frame, 16 up, 5 right, turn, crash frame
    localparam int NumFrames = 24;

    logic Clock;
    logic reset;
    apbRequest apbIn;
    apbResponse apbOut;
    pixelWrite pixel;

    pixelWrite plots[$];
    gridPoint modelBody [BodyLength];
    moveDirection modelDir;
    gridPoint applePoint;
    pixelColour snakeColour;
    logic [23:0] tickPeriod;
    integer seed;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int cycleLimit = 100000;

    benchClock #(
        .Period(ClockPeriod),
        .ResetCycles(2)
    ) u_clock (
        .Clock(Clock),
        .reset(reset)
    );

    snakeGame #(
        .SquareSize(SquareSize),
        .BodyLength(BodyLength)
    ) u_dut (
        .Clock(Clock),
        .reset(reset),
        .apbIn(apbIn),
        .apbOut(apbOut),
        .pixel(pixel)
    );

    // frame buffer stand-in, every plot in order
    always @(posedge Clock)
    begin
        if (!reset && pixel.plot)
            plots.push_back(pixel);
    end

    always @(posedge Clock)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("checks: %0d, errors: %0d", checkCount, errorCount + 1);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        assert (got === expected)
        else
        begin
            errorCount++;
            $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    function automatic logic addressKnown(input logic [7:0] addr);
        case (addr)
            CtrlAddr, DirectionAddr, ColourAddr, AppleAddr, TickAddr, StatusAddr:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // setup cycle, access cycle, then idle
    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        @(negedge Clock);
        apbIn.psel = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite = 1'b1;
        apbIn.paddr = addr;
        apbIn.pwdata = data;
        @(negedge Clock);
        apbIn.penable = 1'b1;
        #(ClockPeriod / 4);
        checkValue("pready", 32'(apbOut.pready), 32'd1);
        checkValue("pslverr", 32'(apbOut.pslverr), 32'(!addressKnown(addr)));
        @(negedge Clock);
        apbIn = '0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
        @(negedge Clock);
        apbIn.psel = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite = 1'b0;
        apbIn.paddr = addr;
        apbIn.pwdata = '0;
        @(negedge Clock);
        apbIn.penable = 1'b1;
        // read data settles within the access cycle
        #(ClockPeriod / 4);
        data = apbOut.prdata;
        checkValue("pready", 32'(apbOut.pready), 32'd1);
        checkValue("pslverr", 32'(apbOut.pslverr), 32'(!addressKnown(addr)));
        @(negedge Clock);
        apbIn = '0;
    endtask

    task automatic waitForPlots(input int count);
        while (plots.size() < count)
            @(negedge Clock);
    endtask

    task automatic resetModel();
        for (int k = 0; k < BodyLength; k++)
        begin
            modelBody[k].x = 8'(ScreenWidth / 2 - k * SquareSize);
            modelBody[k].y = 7'(ScreenHeight / 2);
        end
    endtask

    // head one square on, body follows
    task automatic moveModel(input moveDirection dir);
        int x;
        int y;
        x = int'(modelBody[0].x);
        y = int'(modelBody[0].y);
        case (dir)
            moveRight: x = x + SquareSize;
            moveLeft:  x = x - SquareSize;
            moveDown:  y = y + SquareSize;
            default:   y = y - SquareSize;
        endcase
        x = (x + ScreenWidth) % ScreenWidth;
        y = (y + ScreenHeight) % ScreenHeight;
        for (int k = BodyLength - 1; k > 0; k--)
            modelBody[k] = modelBody[k - 1];
        modelBody[0].x = 8'(x);
        modelBody[0].y = 7'(y);
    endtask

    // head square against segments 2 and up
    function automatic logic bodyOverlaps();
        int dx;
        int dy;
        for (int k = 2; k < BodyLength; k++)
        begin
            dx = int'(modelBody[0].x) - int'(modelBody[k].x);
            dy = int'(modelBody[0].y) - int'(modelBody[k].y);
            if (dx < 0)
                dx = -dx;
            if (dy < 0)
                dy = -dy;
            if (dx < SquareSize && dy < SquareSize)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // row by row, x offset first
    task automatic checkSquare(input int base, input gridPoint corner, input pixelColour colour);
        int index;
        for (int row = 0; row < SquareSize; row++)
        begin
            for (int col = 0; col < SquareSize; col++)
            begin
                index = base + row * SquareSize + col;
                checkValue("pixel.point.x", 32'(plots[index].point.x),
                           32'(int'(corner.x) + col));
                checkValue("pixel.point.y", 32'(plots[index].point.y),
                           32'(int'(corner.y) + row));
                checkValue("pixel.colour", 32'(plots[index].colour), 32'(colour));
            end
        end
    endtask

    task automatic checkBody(input int base, input pixelColour colour);
        for (int k = 0; k < BodyLength; k++)
            checkSquare(base + k * ApplePixels, modelBody[k], colour);
    endtask

    // one whole frame, with an optional turn during the tick wait
    task automatic playFrame(input int frame, input moveDirection dir);
        int base;
        logic ended;
        logic [31:0] data;
        base = frame * FramePixels;
        waitForPlots(base + ApplePixels + BodyPixels);
        checkSquare(base, applePoint, AppleColour);
        checkBody(base + ApplePixels, snakeColour);
        if (dir != modelDir)
        begin
            apbWrite(DirectionAddr, 32'(dir));
            modelDir = dir;
        end
        waitForPlots(base + FramePixels);
        checkBody(base + ApplePixels + BodyPixels, BackgroundColour);
        ended = bodyOverlaps();
        // collision check is over by the access cycle
        apbRead(StatusAddr, data);
        checkValue("status", data, ended ? 32'd1 : 32'd2);
        if (!ended)
            moveModel(modelDir);
    endtask

    task automatic testRegisters();
        logic [31:0] data;
        apbRead(CtrlAddr, data);
        checkValue("ctrl", data, 32'd0);
        apbRead(DirectionAddr, data);
        checkValue("direction", data, 32'(moveRight));
        apbRead(ColourAddr, data);
        checkValue("colour", data, 32'd2);
        apbRead(AppleAddr, data);
        checkValue("apple", data, {17'd0, 7'd30, 8'd30});
        apbRead(TickAddr, data);
        checkValue("tick", data, 32'd1000);
        apbRead(StatusAddr, data);
        checkValue("status", data, 32'd0);

        apbWrite(ColourAddr, 32'(snakeColour));
        apbWrite(AppleAddr, {17'd0, applePoint.y, applePoint.x});
        apbWrite(TickAddr, {8'd0, tickPeriod});
        apbWrite(DirectionAddr, 32'(moveDown));
        apbRead(ColourAddr, data);
        checkValue("colour", data, 32'(snakeColour));
        apbRead(AppleAddr, data);
        checkValue("apple", data, {17'd0, applePoint.y, applePoint.x});
        apbRead(TickAddr, data);
        checkValue("tick", data, {8'd0, tickPeriod});
        apbRead(DirectionAddr, data);
        checkValue("direction", data, 32'(moveDown));
        apbWrite(DirectionAddr, 32'(moveRight));
        apbRead(DirectionAddr, data);
        checkValue("direction", data, 32'(moveRight));

        // status ignores writes
        apbWrite(StatusAddr, 32'h3);
        apbRead(StatusAddr, data);
        checkValue("status", data, 32'd0);

        // unmapped address
        apbWrite(8'h18, 32'h0000dead);
        apbRead(8'h18, data);
        checkValue("prdata", data, 32'd0);
        apbRead(ColourAddr, data);
        checkValue("colour", data, 32'(snakeColour));
        checkValue("plot count", 32'(plots.size()), 32'd0);
    endtask

    task automatic testAppleDraw();
        apbWrite(CtrlAddr, 32'd1);
        waitForPlots(ApplePixels);
        checkSquare(0, applePoint, AppleColour);
    endtask

    task automatic testBodyDraw();
        logic [31:0] data;
        waitForPlots(ApplePixels + BodyPixels);
        checkBody(ApplePixels, snakeColour);
        // tick wait, still running
        apbRead(StatusAddr, data);
        checkValue("status", data, 32'd2);
    endtask

    task automatic testEraseAndMove();
        waitForPlots(FramePixels);
        checkBody(ApplePixels + BodyPixels, BackgroundColour);
        moveModel(modelDir);
        for (int f = 1; f <= 16; f++)
            playFrame(f, moveUp);
        // frame 16 head on the top row, frame 17 head on the bottom row
        waitForPlots(17 * FramePixels + ApplePixels + 1);
        checkValue("head y", 32'(plots[16 * FramePixels + ApplePixels].point.y), 32'd0);
        checkValue("head y", 32'(plots[17 * FramePixels + ApplePixels].point.y),
                   32'(ScreenHeight - SquareSize));
    endtask

    task automatic testSelfCollision();
        logic [31:0] data;
        for (int f = 17; f <= 21; f++)
            playFrame(f, moveRight);
        playFrame(22, moveLeft);
        playFrame(23, moveLeft);

        apbRead(StatusAddr, data);
        checkValue("status", data, 32'd1);
        checkValue("plot count", 32'(plots.size()), 32'(NumFrames * FramePixels));
        repeat (4 * int'(tickPeriod)) @(negedge Clock);
        checkValue("plot count", 32'(plots.size()), 32'(NumFrames * FramePixels));
        apbRead(StatusAddr, data);
        checkValue("status", data, 32'd1);
    endtask

    initial
    begin
        apbIn = '0;
        seed = 32'h1a70;
        tickPeriod = 24'(20 + ($unsigned($random(seed)) % 41));
        snakeColour = 3'b011;
        applePoint.x = 8'd40;
        applePoint.y = 7'd20;
        // register traffic, all frames and the closing wait, with margin
        cycleLimit = 2 * (100 + NumFrames * (FramePixels + int'(tickPeriod) + 8) +
                          5 * int'(tickPeriod));
        resetModel();
        modelDir = moveRight;

        @(negedge Clock);
        while (reset)
            @(negedge Clock);

        testRegisters();
        testAppleDraw();
        testBodyDraw();
        testEraseAndMove();
        testSelfCollision();

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: bench/benchClock.sv
/* clock and reset source for the testbench */
`timescale 1ns/100ps

module benchClock
#(
    parameter int Period = 100,
    parameter int ResetCycles = 2
)
(
    output logic Clock,
    output logic reset
);

    initial
    begin
        Clock = 1'b0;
        forever
            #(Period / 2) Clock = ~Clock;
    end

    // held for a few rising edges, dropped on a falling edge
    initial
    begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;
    end

endmodule

// File: hdl/snakeGame.sv
/* top level: register block beside the painter and the body store */
`timescale 1ns/100ps

module snakeGame
#(
    parameter int SquareSize = 4,
    parameter int BodyLength = 6
)
(
    input logic Clock,
    input logic reset,
    input snakeControlPkg::apbRequest apbIn,
    output snakeControlPkg::apbResponse apbOut,
    output snakeGeometryPkg::pixelWrite pixel
);

    snakeControlPkg::gameConfig gameCfg;
    snakeGeometryPkg::gridPoint segmentPoint;
    logic [2:0] segmentIndex;
    logic moveStep;
    logic hit;
    logic gameOver;
    logic running;

    // software view
    snakeRegisters u_registers (
        .Clock(Clock),
        .reset(reset),
        .apbIn(apbIn),
        .apbOut(apbOut),
        .gameCfg(gameCfg),
        .gameOver(gameOver),
        .running(running)
    );

    // positions and collision
    snakeBody #(
        .SquareSize(SquareSize),
        .BodyLength(BodyLength)
    ) u_body (
        .Clock(Clock),
        .reset(reset),
        .direction(gameCfg.direction),
        .moveStep(moveStep),
        .segmentIndex(segmentIndex),
        .segmentPoint(segmentPoint),
        .hit(hit)
    );

    // frame sequencing and pixel stream
    squarePainter #(
        .SquareSize(SquareSize),
        .BodyLength(BodyLength)
    ) u_painter (
        .Clock(Clock),
        .reset(reset),
        .gameCfg(gameCfg),
        .segmentPoint(segmentPoint),
        .hit(hit),
        .segmentIndex(segmentIndex),
        .moveStep(moveStep),
        .gameOver(gameOver),
        .running(running),
        .pixel(pixel)
    );

endmodule

// File: hdl/squarePainter.sv
/* frame sequencer: apple and body draw, tick wait, erase,
   collision check and the pixel write stream */
`timescale 1ns/100ps

module squarePainter
#(
    parameter int SquareSize = 4,
    parameter int BodyLength = 6
)
(
    input logic Clock,
    input logic reset,
    input snakeControlPkg::gameConfig gameCfg,
    input snakeGeometryPkg::gridPoint segmentPoint,
    input logic hit,
    output logic [2:0] segmentIndex,
    output logic moveStep,
    output logic gameOver,
    output logic running,
    output snakeGeometryPkg::pixelWrite pixel
);
    import snakeGeometryPkg::*;

    painterState state;
    painterState nextState;
    xCoord xOffset;
    yCoord yOffset;
    logic [23:0] tickCount;
    logic plotting;
    logic squareDone;
    logic lastSegment;
    logic tickDone;
    gridPoint corner;

    // one pixel per cycle in these three
    assign plotting = (state == drawApple) || (state == drawBody) || (state == eraseBody);
    assign squareDone = (xOffset == xCoord'(SquareSize - 1)) &&
                        (yOffset == yCoord'(SquareSize - 1));
    assign lastSegment = (segmentIndex == 3'(BodyLength - 1));
    // a zero period behaves like one
    assign tickDone = (tickCount + 24'd1 >= gameCfg.tickPeriod);

    always_comb
    begin
        nextState = state;
        case (state)
            idle:
                if (gameCfg.start)
                    nextState = drawApple;
            drawApple:
                if (squareDone)
                    nextState = drawBody;
            drawBody:
                if (squareDone && lastSegment)
                    nextState = waitTick;
            waitTick:
                if (tickDone)
                    nextState = eraseBody;
            eraseBody:
                if (squareDone && lastSegment)
                    nextState = checkHit;
            checkHit:
                nextState = hit ? snakeGeometryPkg::gameOver : moveSnake;
            moveSnake:
                nextState = drawApple;
            // held until reset
            default:
                nextState = state;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= idle;
            xOffset <= '0;
            yOffset <= '0;
            segmentIndex <= '0;
            tickCount <= '0;
        end
        else
        begin
            state <= nextState;

            // row by row, x first
            if (!plotting || squareDone)
            begin
                xOffset <= '0;
                yOffset <= '0;
            end
            else if (xOffset == xCoord'(SquareSize - 1))
            begin
                xOffset <= '0;
                yOffset <= yOffset + 1'b1;
            end
            else
                xOffset <= xOffset + 1'b1;

            // walk the body, head first
            if ((state == drawBody || state == eraseBody) && squareDone)
                segmentIndex <= lastSegment ? 3'd0 : segmentIndex + 3'd1;
            else if (state != drawBody && state != eraseBody)
                segmentIndex <= '0;

            // counts only while waiting
            if (state == waitTick)
                tickCount <= tickCount + 24'd1;
            else
                tickCount <= '0;
        end
    end

    // apple square or the selected segment
    assign corner = (state == drawApple) ? gameCfg.applePoint : segmentPoint;

    always_comb
    begin
        pixel.point.x = corner.x + xOffset;
        pixel.point.y = corner.y + yOffset;
        pixel.plot = plotting;
        case (state)
            drawApple: pixel.colour = AppleColour;
            drawBody:  pixel.colour = gameCfg.snakeColour;
            default:   pixel.colour = BackgroundColour;
        endcase
    end

    assign moveStep = (state == moveSnake);
    assign gameOver = (state == snakeGeometryPkg::gameOver);
    assign running = (state != idle) && (state != snakeGeometryPkg::gameOver);

    // body squares never leave the visible grid
    bodyOnScreen: assert property (@(posedge Clock) disable iff (reset)
        (state == drawBody || state == eraseBody)
        |-> pixel.point.x < ScreenWidth && pixel.point.y < ScreenHeight);

endmodule

// File: hdl/snakeBody.sv
/* snake position store: head, segment shift register and
   the self-collision test */
`timescale 1ns/100ps

module snakeBody
#(
    parameter int SquareSize = 4,
    // index port is 3 bits wide, so at most 8
    parameter int BodyLength = 6
)
(
    input logic Clock,
    input logic reset,
    input snakeControlPkg::moveDirection direction,
    input logic moveStep,
    input logic [2:0] segmentIndex,
    output snakeGeometryPkg::gridPoint segmentPoint,
    output logic hit
);
    import snakeGeometryPkg::*;
    import snakeControlPkg::*;

    // index 0 is the head
    gridPoint segments [BodyLength];
    gridPoint nextHead;
    int headX;
    int headY;

    // head one square on, wrapping at the edges
    always_comb
    begin
        headX = int'(segments[0].x);
        headY = int'(segments[0].y);
        case (direction)
            moveRight: headX = headX + SquareSize;
            moveLeft:  headX = headX - SquareSize;
            moveDown:  headY = headY + SquareSize;
            moveUp:    headY = headY - SquareSize;
            default:   ;
        endcase
        if (headX >= ScreenWidth)
            headX = headX - ScreenWidth;
        else if (headX < 0)
            headX = headX + ScreenWidth;
        if (headY >= ScreenHeight)
            headY = headY - ScreenHeight;
        else if (headY < 0)
            headY = headY + ScreenHeight;
        nextHead.x = xCoord'(headX);
        nextHead.y = yCoord'(headY);
    end

    // reset layout is a horizontal line left of centre
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            for (int k = 0; k < BodyLength; k++)
            begin
                segments[k].x <= xCoord'(ScreenWidth / 2 - k * SquareSize);
                segments[k].y <= yCoord'(ScreenHeight / 2);
            end
        end
        else if (moveStep)
        begin
            segments[0] <= nextHead;
            // each segment follows the one in front
            for (int k = 1; k < BodyLength; k++)
                segments[k] <= segments[k - 1];
        end
    end

    // painter only selects valid indices
    assign segmentPoint = (segmentIndex < BodyLength) ? segments[segmentIndex] : segments[0];

    // square overlap against segments 2 and beyond
    // segment 1 always touches the head
    always_comb
    begin
        hit = 1'b0;
        for (int k = 2; k < BodyLength; k++)
        begin
            if (int'(segments[0].x) < int'(segments[k].x) + SquareSize &&
                int'(segments[k].x) < int'(segments[0].x) + SquareSize &&
                int'(segments[0].y) < int'(segments[k].y) + SquareSize &&
                int'(segments[k].y) < int'(segments[0].y) + SquareSize)
                hit = 1'b1;
        end
    end

    // wrap logic keeps the head on screen
    headOnScreen: assert property (@(posedge Clock) disable iff (reset)
        segments[0].x < ScreenWidth && segments[0].y < ScreenHeight);

endmodule

// File: hdl/snakeRegisters.sv
/* APB slave with the game control registers and the status readback */
`timescale 1ns/100ps

module snakeRegisters
(
    input logic Clock,
    input logic reset,
    input snakeControlPkg::apbRequest apbIn,
    output snakeControlPkg::apbResponse apbOut,
    output snakeControlPkg::gameConfig gameCfg,
    input logic gameOver,
    input logic running
);
    import snakeControlPkg::*;

    logic accessCycle;
    logic addrValid;
    logic [31:0] readData;

    // second phase of a transfer
    assign accessCycle = apbIn.psel && apbIn.penable;

    // address decode, also builds the read word
    always_comb
    begin
        addrValid = 1'b1;
        readData = '0;
        case (apbIn.paddr)
            CtrlAddr:      readData[0] = gameCfg.start;
            DirectionAddr: readData[1:0] = gameCfg.direction;
            ColourAddr:    readData[2:0] = gameCfg.snakeColour;
            AppleAddr:     readData[14:0] = {gameCfg.applePoint.y, gameCfg.applePoint.x};
            TickAddr:      readData[23:0] = gameCfg.tickPeriod;
            StatusAddr:    readData[1:0] = {running, gameOver};
            default:       addrValid = 1'b0;
        endcase
    end

    // no wait states
    assign apbOut.pready = 1'b1;
    assign apbOut.pslverr = accessCycle && !addrValid;
    assign apbOut.prdata = (accessCycle && addrValid) ? readData : 32'd0;

    // write lands at the end of the access cycle
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            gameCfg.start <= 1'b0;
            gameCfg.direction <= moveRight;
            gameCfg.snakeColour <= 3'b010;
            gameCfg.applePoint.x <= 8'd30;
            gameCfg.applePoint.y <= 7'd30;
            gameCfg.tickPeriod <= 24'd1000;
        end
        else if (accessCycle && apbIn.pwrite)
        begin
            case (apbIn.paddr)
                CtrlAddr:      gameCfg.start <= apbIn.pwdata[0];
                DirectionAddr: gameCfg.direction <= moveDirection'(apbIn.pwdata[1:0]);
                ColourAddr:    gameCfg.snakeColour <= apbIn.pwdata[2:0];
                AppleAddr:
                begin
                    gameCfg.applePoint.x <= apbIn.pwdata[7:0];
                    gameCfg.applePoint.y <= apbIn.pwdata[14:8];
                end
                TickAddr:      gameCfg.tickPeriod <= apbIn.pwdata[23:0];
                // status is read-only, unknown addresses are dropped
                default:       ;
            endcase
        end
    end

    // a setup phase is always followed by its access phase
    setupThenAccess: assert property (@(posedge Clock) disable iff (reset)
        apbIn.psel && !apbIn.penable |=> apbIn.psel && apbIn.penable);

    // painter never reports both at the same time
    statusExclusive: assert property (@(posedge Clock) disable iff (reset)
        !(gameOver && running));

endmodule

// File: hdl/snakeControlPkg.sv
/* APB request and response structs, register addresses,
   direction encoding and the game configuration struct */
package snakeControlPkg;

    // master to slave
    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [7:0] paddr;
        logic [31:0] pwdata;
    } apbRequest;

    // slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic pready;
        logic pslverr;
    } apbResponse;

    // byte addresses of the register map
    typedef enum logic [7:0] {
        CtrlAddr = 8'h00,
        DirectionAddr = 8'h04,
        ColourAddr = 8'h08,
        AppleAddr = 8'h0C,
        TickAddr = 8'h10,
        StatusAddr = 8'h14
    } registerAddress;

    typedef enum logic [1:0] {
        moveRight,
        moveDown,
        moveUp,
        moveLeft
    } moveDirection;

    // everything software steers
    typedef struct packed {
        logic start;
        moveDirection direction;
        snakeGeometryPkg::pixelColour snakeColour;
        snakeGeometryPkg::gridPoint applePoint;
        logic [23:0] tickPeriod;
    } gameConfig;

endpackage

// File: hdl/snakeGeometryPkg.sv
/* screen size, coordinate and pixel types, colour constants
   and the painter state encoding */
package snakeGeometryPkg;

    // visible grid in pixels
    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;

    typedef logic [7:0] xCoord;
    typedef logic [6:0] yCoord;

    // top-left corner of one square
    typedef struct packed {
        xCoord x;
        yCoord y;
    } gridPoint;

    // one bit per channel, RGB
    typedef logic [2:0] pixelColour;

    localparam pixelColour AppleColour = 3'b100;
    localparam pixelColour BackgroundColour = 3'b000;

    // one write into the frame buffer
    typedef struct packed {
        gridPoint point;
        pixelColour colour;
        logic plot;
    } pixelWrite;

    // frame sequencer phases
    typedef enum logic [2:0] {
        idle,
        drawApple,
        drawBody,
        waitTick,
        eraseBody,
        checkHit,
        moveSnake,
        gameOver
    } painterState;

endpackage
